// ==== include/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// ============================================================
// rename stage sizing
// ============================================================

// architectural registers, x0 included
`define RENAME_AREGS 32

// physical registers, the free list holds the ones not mapped
`define RENAME_PREGS 64

// group slots the issue queue can take
`define RENAME_CREDITS 4

`endif

// ==== source/rename_pkg.sv ====
`include "rename_config.svh"

package rename_pkg;

	// ============================================================
	// register and tag types
	// ============================================================

	// architectural register index
	typedef logic [$clog2(`RENAME_AREGS)-1:0] areg_t;

	// physical tag
	typedef logic [$clog2(`RENAME_PREGS)-1:0] preg_t;

	// free-list occupancy, 0 up to a full list
	typedef logic [$clog2(`RENAME_PREGS + 1)-1:0] free_cnt_t;

	// raw opcode field, only bits 1:0 carry the class
	typedef logic [5:0] opcode_t;

	// instruction classes
	typedef enum logic [1:0] {
		// writes rd, reads rs1 and rs2
		OP_ALU    = 2'd0,
		// writes rd, reads rs1
		OP_LOAD   = 2'd1,
		// reads rs1 and rs2
		OP_STORE  = 2'd2,
		// reads rs1 and rs2
		OP_BRANCH = 2'd3
	} op_class_t;

endpackage

// ==== source/rename_decode.sv ====
`timescale 1ns/1ps

module rename_decode (
	input  logic                  in_valid,
	input  logic                  in_valid1,
	input  logic [31:0]           in_insn0,
	input  logic [31:0]           in_insn1,
	input  rename_pkg::free_cnt_t free_count,
	input  logic                  has_credit,
	output logic                  in_ready,
	output logic                  accept,
	output rename_pkg::areg_t     rd0,
	output rename_pkg::areg_t     rd1,
	output rename_pkg::areg_t     rs1_0,
	output rename_pkg::areg_t     rs1_1,
	output rename_pkg::areg_t     rs2_0,
	output rename_pkg::areg_t     rs2_1,
	output logic                  need_dst0,
	output logic                  need_dst1,
	output logic                  use_rs2_0,
	output logic                  use_rs2_1,
	output logic [1:0]            pop_count
);
	import rename_pkg::*;

	op_class_t cls0;
	op_class_t cls1;
	opcode_t   opc0;
	opcode_t   opc1;
	logic [1:0] dst_count;
	logic       well_formed;

	// ============================================================
	// field split
	// ============================================================

	// opcode 31:26, rd 25:21, rs1 20:16, rs2 15:11
	assign opc0  = in_insn0[31:26];
	assign opc1  = in_insn1[31:26];
	assign rd0   = in_insn0[25:21];
	assign rd1   = in_insn1[25:21];
	assign rs1_0 = in_insn0[20:16];
	assign rs1_1 = in_insn1[20:16];
	assign rs2_0 = in_insn0[15:11];
	assign rs2_1 = in_insn1[15:11];

	// class lives in the low opcode bits, the rest is ignored
	assign cls0 = op_class_t'(opc0[1:0]);
	assign cls1 = op_class_t'(opc1[1:0]);

	// ============================================================
	// classification
	// ============================================================

	// alu and load write rd, x0 never takes a tag
	assign need_dst0 = (cls0 == OP_ALU || cls0 == OP_LOAD) && (rd0 != '0);
	// slot 1 only counts when it carries an instruction
	assign need_dst1 = in_valid1 && (cls1 == OP_ALU || cls1 == OP_LOAD) && (rd1 != '0);

	// loads are the only class without a second source
	assign use_rs2_0 = (cls0 != OP_LOAD);
	assign use_rs2_1 = (cls1 != OP_LOAD);

	// ============================================================
	// acceptance
	// ============================================================

	assign dst_count = {1'b0, need_dst0} + {1'b0, need_dst1};

	// slot 1 may only ride along with slot 0
	assign well_formed = !in_valid1 || in_valid;

	// enough credit, enough free tags, legal slot use
	assign in_ready = has_credit && (free_count >= free_cnt_t'(dst_count)) && well_formed;
	assign accept   = in_valid && in_ready;

	// the free list only moves on an accepted group
	assign pop_count = accept ? dst_count : 2'd0;

	// upstream must fill slots in order
	always_comb
	begin
		assert (!in_valid1 || in_valid)
			else $error("rename_decode: in_valid1 without in_valid");
	end

endmodule

// ==== source/rename_free_list.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_free_list (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [1:0]            pop_count,
	input  logic                  push0,
	input  rename_pkg::preg_t     push_tag0,
	input  logic                  push1,
	input  rename_pkg::preg_t     push_tag1,
	output rename_pkg::preg_t     head_tag0,
	output rename_pkg::preg_t     head_tag1,
	output rename_pkg::free_cnt_t free_count
);
	import rename_pkg::*;

	localparam int PTR_W = $clog2(`RENAME_PREGS);
	localparam int NFREE = `RENAME_PREGS - `RENAME_AREGS;

	preg_t            mem [`RENAME_PREGS];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] head_p1;
	logic [PTR_W-1:0] tail_p1;
	free_cnt_t        count;

	// ============================================================
	// read side
	// ============================================================

	assign head_p1 = head + PTR_W'(1);
	assign tail_p1 = tail + PTR_W'(1);

	// the two oldest free tags, slot 0 takes the head
	assign head_tag0  = mem[head];
	assign head_tag1  = mem[head_p1];
	assign free_count = count;

	// ============================================================
	// pointer, count and storage update
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// free tags AREGS..PREGS-1 sit at the bottom in order
			// slots beyond the tail are don't care
			for (int i = 0; i < `RENAME_PREGS; i++)
				mem[i] <= preg_t'(`RENAME_AREGS + i);
			head  <= '0;
			tail  <= PTR_W'(NFREE);
			count <= free_cnt_t'(NFREE);
		end
		else
		begin
			// commit slot 0 lands first, a lone slot 1 takes the tail itself
			if (push0)
			begin
				mem[tail] <= push_tag0;
				if (push1)
					mem[tail_p1] <= push_tag1;
			end
			else if (push1)
			begin
				mem[tail] <= push_tag1;
			end

			tail  <= tail + PTR_W'(push0) + PTR_W'(push1);
			head  <= head + PTR_W'(pop_count);
			count <= count + free_cnt_t'(push0) + free_cnt_t'(push1)
				- free_cnt_t'(pop_count);
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// decode must never hand out more tags than are queued
	a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n)
		free_cnt_t'(pop_count) <= count)
		else $error("rename_free_list: pop of %0d with %0d free", pop_count, count);

	// commit may not return more tags than the queue can hold
	a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
		(int'(count) + int'(push0) + int'(push1)) <= `RENAME_PREGS)
		else $error("rename_free_list: push beyond capacity, count %0d", count);

endmodule

// ==== source/rename_map_table.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_map_table (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              accept,
	input  rename_pkg::areg_t rd0,
	input  rename_pkg::areg_t rd1,
	input  rename_pkg::areg_t rs1_0,
	input  rename_pkg::areg_t rs1_1,
	input  rename_pkg::areg_t rs2_0,
	input  rename_pkg::areg_t rs2_1,
	input  logic              use_rs2_0,
	input  logic              use_rs2_1,
	input  logic              need_dst0,
	input  logic              need_dst1,
	input  rename_pkg::preg_t head_tag0,
	input  rename_pkg::preg_t head_tag1,
	output rename_pkg::preg_t psrc1_0,
	output rename_pkg::preg_t psrc1_1,
	output rename_pkg::preg_t psrc2_0,
	output rename_pkg::preg_t psrc2_1,
	output rename_pkg::preg_t pdst0,
	output rename_pkg::preg_t pdst1,
	output rename_pkg::preg_t old_pdst0,
	output rename_pkg::preg_t old_pdst1
);
	import rename_pkg::*;

	preg_t map_q [`RENAME_AREGS];

	// x0 and unused sources read tag 0
	function automatic preg_t src_tag(areg_t a, logic en, preg_t mapped);
		if (!en || a == '0)
			return '0;
		return mapped;
	endfunction

	// ============================================================
	// new destination tags
	// ============================================================

	assign pdst0 = need_dst0 ? head_tag0 : '0;
	// slot 1 skips the head only when slot 0 took it
	assign pdst1 = need_dst1 ? (need_dst0 ? head_tag1 : head_tag0) : '0;

	// ============================================================
	// lookup with intra-group bypass
	// ============================================================

	// slot 0 sees the table as it is
	assign psrc1_0 = src_tag(rs1_0, 1'b1, map_q[rs1_0]);
	assign psrc2_0 = src_tag(rs2_0, use_rs2_0, map_q[rs2_0]);

	// slot 1 sees slot 0's write first, need_dst0 already excludes x0
	assign psrc1_1 = (need_dst0 && rs1_1 == rd0) ? pdst0
		: src_tag(rs1_1, 1'b1, map_q[rs1_1]);
	assign psrc2_1 = (use_rs2_1 && need_dst0 && rs2_1 == rd0) ? pdst0
		: src_tag(rs2_1, use_rs2_1, map_q[rs2_1]);

	// displaced tags, slot 1 displaces slot 0's tag on a shared rd
	assign old_pdst0 = need_dst0 ? map_q[rd0] : '0;
	assign old_pdst1 = !need_dst1 ? '0
		: (need_dst0 && rd1 == rd0) ? pdst0 : map_q[rd1];

	// ============================================================
	// table update
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// identity map, arch i lives in phys i
			for (int i = 0; i < `RENAME_AREGS; i++)
				map_q[i] <= preg_t'(i);
		end
		else if (accept)
		begin
			if (need_dst0)
				map_q[rd0] <= pdst0;
			// later write wins, so a shared rd keeps slot 1's tag
			if (need_dst1)
				map_q[rd1] <= pdst1;
		end
	end

endmodule

// ==== source/rename_result.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_result (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              accept,
	input  logic              in_valid1,
	input  rename_pkg::preg_t pdst0,
	input  rename_pkg::preg_t pdst1,
	input  rename_pkg::preg_t psrc1_0,
	input  rename_pkg::preg_t psrc1_1,
	input  rename_pkg::preg_t psrc2_0,
	input  rename_pkg::preg_t psrc2_1,
	input  rename_pkg::preg_t old_pdst0,
	input  rename_pkg::preg_t old_pdst1,
	input  logic              need_dst0,
	input  logic              need_dst1,
	input  logic              credit_return,
	output logic              has_credit,
	output logic              out_valid,
	output logic              out_valid1,
	output rename_pkg::preg_t out_pdst0,
	output rename_pkg::preg_t out_pdst1,
	output rename_pkg::preg_t out_psrc1_0,
	output rename_pkg::preg_t out_psrc1_1,
	output rename_pkg::preg_t out_psrc2_0,
	output rename_pkg::preg_t out_psrc2_1,
	output rename_pkg::preg_t out_old_pdst0,
	output rename_pkg::preg_t out_old_pdst1,
	output logic              out_has_dst0,
	output logic              out_has_dst1
);
	localparam int CREDIT_W = $clog2(`RENAME_CREDITS + 1);

	logic [CREDIT_W-1:0] credit_cnt;

	// ============================================================
	// valid and credit counter
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid  <= 1'b0;
			out_valid1 <= 1'b0;
			credit_cnt <= CREDIT_W'(`RENAME_CREDITS);
		end
		else
		begin
			// one pulse per accepted group
			out_valid  <= accept;
			out_valid1 <= accept && in_valid1;
			// take and return may meet in one cycle
			credit_cnt <= credit_cnt + CREDIT_W'(credit_return) - CREDIT_W'(accept);
		end
	end

	assign has_credit = (credit_cnt != '0);

	// payload only moves with a group
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_pdst0     <= pdst0;
			out_pdst1     <= pdst1;
			out_psrc1_0   <= psrc1_0;
			out_psrc1_1   <= psrc1_1;
			out_psrc2_0   <= psrc2_0;
			out_psrc2_1   <= psrc2_1;
			out_old_pdst0 <= old_pdst0;
			out_old_pdst1 <= old_pdst1;
			out_has_dst0  <= need_dst0;
			out_has_dst1  <= need_dst1;
		end
	end

	// the issue queue never returns more than it was given
	a_credit_bound : assert property (@(posedge clk) disable iff (!arst_n)
		int'(credit_cnt) <= `RENAME_CREDITS)
		else $error("rename_result: credit count %0d above limit", credit_cnt);

	// decode only accepts with a credit in hand
	a_credit_take : assert property (@(posedge clk) disable iff (!arst_n)
		accept |-> credit_cnt != '0)
		else $error("rename_result: group accepted with no credit");

endmodule

// ==== source/rename_top.sv ====
`timescale 1ns/1ps

module rename_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  logic [31:0]       in_insn0,
	input  logic [31:0]       in_insn1,
	input  logic              in_valid1,
	input  logic              commit_valid0,
	input  rename_pkg::preg_t commit_tag0,
	input  logic              commit_valid1,
	input  rename_pkg::preg_t commit_tag1,
	input  logic              credit_return,
	output logic              in_ready,
	output logic              out_valid,
	output logic              out_valid1,
	output rename_pkg::preg_t out_pdst0,
	output rename_pkg::preg_t out_pdst1,
	output rename_pkg::preg_t out_psrc1_0,
	output rename_pkg::preg_t out_psrc1_1,
	output rename_pkg::preg_t out_psrc2_0,
	output rename_pkg::preg_t out_psrc2_1,
	output rename_pkg::preg_t out_old_pdst0,
	output rename_pkg::preg_t out_old_pdst1,
	output logic              out_has_dst0,
	output logic              out_has_dst1
);
	import rename_pkg::*;

	// ============================================================
	// inter-block wires
	// ============================================================

	logic      accept;
	logic      has_credit;
	logic      need_dst0;
	logic      need_dst1;
	logic      use_rs2_0;
	logic      use_rs2_1;
	logic [1:0] pop_count;
	areg_t     rd0;
	areg_t     rd1;
	areg_t     rs1_0;
	areg_t     rs1_1;
	areg_t     rs2_0;
	areg_t     rs2_1;
	free_cnt_t free_count;
	preg_t     head_tag0;
	preg_t     head_tag1;
	preg_t     pdst0;
	preg_t     pdst1;
	preg_t     psrc1_0;
	preg_t     psrc1_1;
	preg_t     psrc2_0;
	preg_t     psrc2_1;
	preg_t     old_pdst0;
	preg_t     old_pdst1;

	// decode, the only acceptance point
	rename_decode u_decode (
		.in_valid   (in_valid),
		.in_valid1  (in_valid1),
		.in_insn0   (in_insn0),
		.in_insn1   (in_insn1),
		.free_count (free_count),
		.has_credit (has_credit),
		.in_ready   (in_ready),
		.accept     (accept),
		.rd0        (rd0),
		.rd1        (rd1),
		.rs1_0      (rs1_0),
		.rs1_1      (rs1_1),
		.rs2_0      (rs2_0),
		.rs2_1      (rs2_1),
		.need_dst0  (need_dst0),
		.need_dst1  (need_dst1),
		.use_rs2_0  (use_rs2_0),
		.use_rs2_1  (use_rs2_1),
		.pop_count  (pop_count)
	);

	// free tags, commit pushes straight in
	rename_free_list u_free_list (
		.clk        (clk),
		.arst_n     (arst_n),
		.pop_count  (pop_count),
		.push0      (commit_valid0),
		.push_tag0  (commit_tag0),
		.push1      (commit_valid1),
		.push_tag1  (commit_tag1),
		.head_tag0  (head_tag0),
		.head_tag1  (head_tag1),
		.free_count (free_count)
	);

	// rename proper
	rename_map_table u_map_table (
		.clk       (clk),
		.arst_n    (arst_n),
		.accept    (accept),
		.rd0       (rd0),
		.rd1       (rd1),
		.rs1_0     (rs1_0),
		.rs1_1     (rs1_1),
		.rs2_0     (rs2_0),
		.rs2_1     (rs2_1),
		.use_rs2_0 (use_rs2_0),
		.use_rs2_1 (use_rs2_1),
		.need_dst0 (need_dst0),
		.need_dst1 (need_dst1),
		.head_tag0 (head_tag0),
		.head_tag1 (head_tag1),
		.psrc1_0   (psrc1_0),
		.psrc1_1   (psrc1_1),
		.psrc2_0   (psrc2_0),
		.psrc2_1   (psrc2_1),
		.pdst0     (pdst0),
		.pdst1     (pdst1),
		.old_pdst0 (old_pdst0),
		.old_pdst1 (old_pdst1)
	);

	// output register and downstream credits
	rename_result u_result (
		.clk           (clk),
		.arst_n        (arst_n),
		.accept        (accept),
		.in_valid1     (in_valid1),
		.pdst0         (pdst0),
		.pdst1         (pdst1),
		.psrc1_0       (psrc1_0),
		.psrc1_1       (psrc1_1),
		.psrc2_0       (psrc2_0),
		.psrc2_1       (psrc2_1),
		.old_pdst0     (old_pdst0),
		.old_pdst1     (old_pdst1),
		.need_dst0     (need_dst0),
		.need_dst1     (need_dst1),
		.credit_return (credit_return),
		.has_credit    (has_credit),
		.out_valid     (out_valid),
		.out_valid1    (out_valid1),
		.out_pdst0     (out_pdst0),
		.out_pdst1     (out_pdst1),
		.out_psrc1_0   (out_psrc1_0),
		.out_psrc1_1   (out_psrc1_1),
		.out_psrc2_0   (out_psrc2_0),
		.out_psrc2_1   (out_psrc2_1),
		.out_old_pdst0 (out_old_pdst0),
		.out_old_pdst1 (out_old_pdst1),
		.out_has_dst0  (out_has_dst0),
		.out_has_dst1  (out_has_dst1)
	);

endmodule

// ==== tb/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_tb;
	import rename_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_ROW = 100;
	localparam logic [31:0] IDLE = 32'h0;

	// flag bits of a table row
	localparam int F_VALID = 6;
	localparam int F_VALID1 = 5;
	localparam int F_CV0 = 4;
	localparam int F_CV1 = 3;
	localparam int F_RET = 2;
	localparam int F_RDY = 1;
	localparam int F_RND = 0;

	typedef struct packed {
		logic [6:0]  flags;
		logic [31:0] insn0;
		logic [31:0] insn1;
	} row_t;

	// what one row should produce, plus its commit pushes
	typedef struct packed {
		logic  acc;
		logic  v1;
		logic  nd0;
		logic  nd1;
		areg_t rd0;
		areg_t rd1;
		preg_t pd0;
		preg_t pd1;
		preg_t ps1_0;
		preg_t ps2_0;
		preg_t ps1_1;
		preg_t ps2_1;
		preg_t old0;
		preg_t old1;
		logic  cv0;
		logic  cv1;
		preg_t ct0;
		preg_t ct1;
	} exp_t;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	logic [31:0] in_insn0;
	logic [31:0] in_insn1;
	logic        in_valid1;
	logic        commit_valid0;
	preg_t       commit_tag0;
	logic        commit_valid1;
	preg_t       commit_tag1;
	logic        credit_return;
	logic        in_ready;
	logic        out_valid;
	logic        out_valid1;
	preg_t       out_pdst0;
	preg_t       out_pdst1;
	preg_t       out_psrc1_0;
	preg_t       out_psrc1_1;
	preg_t       out_psrc2_0;
	preg_t       out_psrc2_1;
	preg_t       out_old_pdst0;
	preg_t       out_old_pdst1;
	logic        out_has_dst0;
	logic        out_has_dst1;

	// reference map, free tag FIFO and displaced tags awaiting commit
	row_t  rows[$];
	preg_t map_m [`RENAME_AREGS];
	preg_t free_q[$];
	preg_t retire_q[$];

	rename_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ============================================================
	// instruction building and field rules
	// ============================================================

	// opcode 31:26 with class in 27:26, rd 25:21, rs1 20:16, rs2 15:11
	function automatic logic [31:0] ins(op_class_t c, int rd, int rs1, int rs2);
		return {4'h5, c, 5'(rd), 5'(rs1), 5'(rs2), 11'h0};
	endfunction

	// alu or load with a nonzero rd, junk in the ignored opcode bits
	function automatic logic [31:0] random_insn();
		logic [3:0] hi;
		op_class_t  c;
		hi = 4'($urandom());
		c = $urandom_range(1, 0) ? OP_LOAD : OP_ALU;
		return {hi, c, 5'($urandom_range(31, 1)), 5'($urandom()), 5'($urandom()), 11'h0};
	endfunction

	function automatic logic writes_rd(logic [31:0] insn);
		op_class_t c;
		c = op_class_t'(insn[27:26]);
		return (c == OP_ALU || c == OP_LOAD) && insn[25:21] != 5'd0;
	endfunction

	function automatic logic reads_rs2(logic [31:0] insn);
		return op_class_t'(insn[27:26]) != OP_LOAD;
	endfunction

	// x0 and unused sources read tag 0
	function automatic preg_t lookup(areg_t a, logic en);
		if (!en || a == 5'd0)
			return '0;
		return map_m[a];
	endfunction

	// ============================================================
	// stimulus table
	// ============================================================

	task automatic add_row(input logic [6:0] flags, input logic [31:0] i0, input logic [31:0] i1);
		row_t r;
		r.flags = flags;
		r.insn0 = i0;
		r.insn1 = i1;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// flag order is valid valid1 _ commit0 commit1 _ credit_return expect_ready random
		// fresh tags, bypass, shared rd, tagless classes, single slot
		add_row(7'b11_00_010, ins(OP_ALU, 5, 1, 2), ins(OP_ALU, 6, 5, 3));
		add_row(7'b11_00_110, ins(OP_ALU, 8, 5, 6), ins(OP_ALU, 8, 8, 0));
		add_row(7'b11_00_110, ins(OP_STORE, 9, 6, 0), ins(OP_BRANCH, 0, 8, 5));
		add_row(7'b11_00_110, ins(OP_ALU, 0, 0, 7), ins(OP_LOAD, 9, 8, 4));
		add_row(7'b10_00_110, ins(OP_LOAD, 10, 0, 3), ins(OP_ALU, 11, 1, 1));
		add_row(7'b00_00_110, IDLE, IDLE);
		// drain the free list down to two tags
		for (int i = 0; i < 12; i++)
			add_row(7'b11_00_111, IDLE, IDLE);
		add_row(7'b10_00_110, ins(OP_ALU, 12, 1, 2), IDLE);
		// one free tag, group needs two, a commit refills it
		add_row(7'b11_00_000, ins(OP_ALU, 13, 12, 10), ins(OP_LOAD, 14, 13, 0));
		add_row(7'b11_10_000, ins(OP_ALU, 13, 12, 10), ins(OP_LOAD, 14, 13, 0));
		add_row(7'b11_00_010, ins(OP_ALU, 13, 12, 10), ins(OP_LOAD, 14, 13, 0));
		add_row(7'b00_11_110, IDLE, IDLE);
		add_row(7'b00_11_010, IDLE, IDLE);
		// steady state, committed tags recycled in order
		for (int i = 0; i < 6; i++)
			add_row(7'b11_11_111, IDLE, IDLE);
		// no returns, credits run out after four groups
		for (int i = 0; i < 4; i++)
			add_row(7'b11_11_011, IDLE, IDLE);
		add_row(7'b11_00_000, ins(OP_ALU, 20, 13, 14), ins(OP_ALU, 21, 20, 20));
		add_row(7'b11_00_100, ins(OP_ALU, 20, 13, 14), ins(OP_ALU, 21, 20, 20));
		add_row(7'b11_00_010, ins(OP_ALU, 20, 13, 14), ins(OP_ALU, 21, 20, 20));
		add_row(7'b11_00_000, ins(OP_LOAD, 22, 21, 0), ins(OP_ALU, 23, 22, 1));
		add_row(7'b00_00_100, IDLE, IDLE);
		for (int i = 0; i < 3; i++)
			add_row(7'b00_00_110, IDLE, IDLE);
	endtask

	// ============================================================
	// reference model
	// ============================================================

	task automatic reset_model();
		free_q.delete();
		retire_q.delete();
		for (int i = 0; i < `RENAME_AREGS; i++)
			map_m[i] = preg_t'(i);
		// tags above the architectural range start out free, ascending
		for (int i = `RENAME_AREGS; i < `RENAME_PREGS; i++)
			free_q.push_back(preg_t'(i));
	endtask

	task automatic take_retired(output preg_t t);
		assert (retire_q.size() > 0)
		else
		begin
			$display("a commit was requested while no displaced tag was waiting");
			$display("Simulation failed");
			$fatal(1);
		end
		t = retire_q.pop_front();
	endtask

	task automatic drive_idle();
		in_valid = 1'b0;
		in_valid1 = 1'b0;
		in_insn0 = IDLE;
		in_insn1 = IDLE;
		commit_valid0 = 1'b0;
		commit_tag0 = '0;
		commit_valid1 = 1'b0;
		commit_tag1 = '0;
		credit_return = 1'b0;
	endtask

	// drives one row and predicts it from the state before the next edge
	task automatic drive_row(input row_t r, output exp_t e);
		areg_t rs1_0;
		areg_t rs2_0;
		areg_t rs1_1;
		areg_t rs2_1;
		logic  use2_1;
		e = '0;
		e.cv0 = r.flags[F_CV0];
		e.cv1 = r.flags[F_CV1];
		if (e.cv0)
			take_retired(e.ct0);
		if (e.cv1)
			take_retired(e.ct1);
		in_valid = r.flags[F_VALID];
		in_valid1 = r.flags[F_VALID1];
		in_insn0 = r.insn0;
		in_insn1 = r.insn1;
		commit_valid0 = e.cv0;
		commit_tag0 = e.ct0;
		commit_valid1 = e.cv1;
		commit_tag1 = e.ct1;
		credit_return = r.flags[F_RET];

		e.acc = r.flags[F_VALID] && r.flags[F_RDY];
		e.v1 = r.flags[F_VALID1];
		e.rd0 = r.insn0[25:21];
		e.rd1 = r.insn1[25:21];
		rs1_0 = r.insn0[20:16];
		rs2_0 = r.insn0[15:11];
		rs1_1 = r.insn1[20:16];
		rs2_1 = r.insn1[15:11];
		use2_1 = reads_rs2(r.insn1);
		e.nd0 = writes_rd(r.insn0);
		e.nd1 = e.v1 && writes_rd(r.insn1);
		if (e.acc)
		begin
			// slot 0 takes the head, slot 1 the next unused one
			e.pd0 = e.nd0 ? free_q[0] : '0;
			e.pd1 = !e.nd1 ? '0 : (e.nd0 ? free_q[1] : free_q[0]);
			e.ps1_0 = lookup(rs1_0, 1'b1);
			e.ps2_0 = lookup(rs2_0, reads_rs2(r.insn0));
			// slot 1 sources see slot 0's rename
			e.ps1_1 = (e.nd0 && rs1_1 == e.rd0) ? e.pd0 : lookup(rs1_1, 1'b1);
			e.ps2_1 = (use2_1 && e.nd0 && rs2_1 == e.rd0) ? e.pd0 : lookup(rs2_1, use2_1);
			e.old0 = map_m[e.rd0];
			e.old1 = (e.nd0 && e.rd1 == e.rd0) ? e.pd0 : map_m[e.rd1];
		end
	endtask

	// pops and map writes first, commit pushes land at the tail after them
	task automatic apply_edge(input exp_t e);
		if (e.acc && e.nd0)
		begin
			void'(free_q.pop_front());
			map_m[e.rd0] = e.pd0;
			retire_q.push_back(e.old0);
		end
		if (e.acc && e.nd1)
		begin
			void'(free_q.pop_front());
			map_m[e.rd1] = e.pd1;
			retire_q.push_back(e.old1);
		end
		if (e.cv0)
			free_q.push_back(e.ct0);
		if (e.cv1)
			free_q.push_back(e.ct1);
	endtask

	// ============================================================
	// checks
	// ============================================================

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_tag(input string name, input preg_t got, input preg_t exp);
		assert (got === exp)
		else
		begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// group accepted at the last edge must be on the outputs now, once
	task automatic check_group(input exp_t e);
		check_bit("out_valid", out_valid, e.acc);
		check_bit("out_valid1", out_valid1, e.acc && e.v1);
		if (e.acc)
		begin
			check_bit("out_has_dst0", out_has_dst0, e.nd0);
			check_tag("out_psrc1_0", out_psrc1_0, e.ps1_0);
			check_tag("out_psrc2_0", out_psrc2_0, e.ps2_0);
			if (e.nd0)
			begin
				check_tag("out_pdst0", out_pdst0, e.pd0);
				check_tag("out_old_pdst0", out_old_pdst0, e.old0);
			end
			if (e.v1)
			begin
				check_bit("out_has_dst1", out_has_dst1, e.nd1);
				check_tag("out_psrc1_1", out_psrc1_1, e.ps1_1);
				check_tag("out_psrc2_1", out_psrc2_1, e.ps2_1);
				if (e.nd1)
				begin
					check_tag("out_pdst1", out_pdst1, e.pd1);
					check_tag("out_old_pdst1", out_old_pdst1, e.old1);
				end
			end
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial
	begin
		row_t r;
		exp_t cur;
		exp_t prev;
		void'($urandom(32'hd2d4));
		build_table();
		reset_model();
		prev = '0;
		arst_n = 1'b0;
		drive_idle();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;

		// one row per cycle, driven just after the edge, checked at the falling edge
		for (int i = 0; i < rows.size(); i++)
		begin
			@(posedge clk);
			apply_edge(prev);
			#2;
			r = rows[i];
			if (r.flags[F_RND])
			begin
				r.insn0 = random_insn();
				r.insn1 = random_insn();
			end
			drive_row(r, cur);
			@(negedge clk);
			check_group(prev);
			check_bit("in_ready", in_ready, r.flags[F_RDY]);
			prev = cur;
		end

		// last group leaves the output register
		@(posedge clk);
		apply_edge(prev);
		#2;
		drive_idle();
		@(negedge clk);
		check_group(prev);
		$display("Simulation completed successfully");
		$finish;
	end

	// budget scales with the table, reset included
	initial
	begin
		#1;
		repeat (rows.size() * CYCLES_PER_ROW + RESET_CYCLES) @(posedge clk);
		$display("Timeout: the stimulus table did not finish in its cycle budget");
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

// ==== sources.f ====
+incdir+include
source/rename_pkg.sv
source/rename_decode.sv
source/rename_free_list.sv
source/rename_map_table.sv
source/rename_result.sv
source/rename_top.sv
tb/rename_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module rename_tb -Mdir obj_dir \
	&& ./obj_dir/Vrename_tb > sim.log 2>&1 \
	|| echo "build or run ended abnormally" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
